// File: source/host_tester_pkg.sv
// Widths, APB register map and internal structs of the host tester node
// Message width is fixed here because the APB register layout is built around it
package host_tester_pkg;

    // Channel message width
    localparam int MSG_WIDTH = 64;
    // Source count and per-test message counters
    localparam int COUNT_WIDTH = 31;

    // APB port widths
    localparam int APB_ADDR_WIDTH = 8;
    localparam int APB_DATA_WIDTH = 32;

    // Count field of a REG_CTRL write sits above the 2-bit mode
    localparam int CMD_COUNT_WIDTH = APB_DATA_WIDTH - 2;

    // Test modes, encoded as in REG_CTRL bits 1:0
    typedef enum logic [1:0]
    {
        MODE_NORMAL   = 2'd0,
        MODE_SINK     = 2'd1,
        MODE_SOURCE   = 2'd2,
        MODE_LOOPBACK = 2'd3
    }
    tester_mode_e;

    // Register byte offsets
    typedef enum logic [APB_ADDR_WIDTH-1:0]
    {
        REG_CTRL     = 8'h00,
        REG_STATUS   = 8'h04,
        REG_TX_COUNT = 8'h08,
        REG_RX_COUNT = 8'h0C
    }
    csr_reg_e;

    // One-cycle test request from the decoder
    typedef struct packed
    {
        logic                       start;
        tester_mode_e               mode;
        logic [CMD_COUNT_WIDTH-1:0] count;
    }
    tester_cmd_t;

    // Per-cycle activity seen by the router
    typedef struct packed
    {
        tester_mode_e mode;
        logic         host_rx_fire;
        logic         host_tx_fire;
        logic         done;
    }
    route_event_t;

    // Status block returned on APB reads
    typedef struct packed
    {
        tester_mode_e           mode;
        logic                   done;
        logic [COUNT_WIDTH-1:0] tx_count;
        logic [COUNT_WIDTH-1:0] rx_count;
    }
    tester_status_t;

endpackage

// File: source/host_tester_csr.sv
// APB slave with one wait state on every access
// REG_CTRL is write-only; a write with mode 0 is accepted and ignored
module host_tester_csr
(
    input  logic                                       clk,
    input  logic                                       resetb,

    // APB slave port
    input  logic [host_tester_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic                                       psel,
    input  logic                                       penable,
    input  logic                                       pwrite,
    input  logic [host_tester_pkg::APB_DATA_WIDTH-1:0] pwdata,
    output logic [host_tester_pkg::APB_DATA_WIDTH-1:0] prdata,
    output logic                                       pready,
    output logic                                       pslverr,

    // Test command to the router
    output host_tester_pkg::tester_cmd_t               cmd,
    // Status from the recorder
    input  host_tester_pkg::tester_status_t            status
);
    import host_tester_pkg::*;

    logic                       access;
    csr_reg_e                   offset;
    tester_mode_e               wr_mode;
    logic [APB_DATA_WIDTH-1:0]  rd_data;
    logic                       rd_err;
    logic                       wr_err;

    logic                       start_q;
    tester_mode_e               mode_q;
    logic [CMD_COUNT_WIDTH-1:0] count_q;

    // Access cycle is the setup-complete cycle before pready rises
    assign access = psel && penable && !pready;
    assign offset = csr_reg_e'(paddr);
    assign wr_mode = tester_mode_e'(pwdata[1:0]);

    // Offset decode and read mux
    always_comb
    begin
        rd_data = '0;
        rd_err = 1'b0;
        // Only REG_CTRL is writable
        wr_err = 1'b1;
        case (offset)
            REG_CTRL:
            begin
                rd_err = 1'b1;
                wr_err = 1'b0;
            end
            REG_STATUS:
            begin
                rd_data = APB_DATA_WIDTH'({status.done, status.mode});
            end
            REG_TX_COUNT:
            begin
                rd_data = APB_DATA_WIDTH'(status.tx_count);
            end
            REG_RX_COUNT:
            begin
                rd_data = APB_DATA_WIDTH'(status.rx_count);
            end
            default:
            begin
                // Unmapped offset
                rd_err = 1'b1;
            end
        endcase
    end

    // Handshake and start pulse
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            pready <= 1'b0;
            pslverr <= 1'b0;
            start_q <= 1'b0;
        end
        else
        begin
            pready <= access;
            pslverr <= access && (pwrite ? wr_err : rd_err);
            // Mode 0 writes do not start anything
            start_q <= access && pwrite && (offset == REG_CTRL) && (wr_mode != MODE_NORMAL);
        end
    end

    // Read data and command payload, captured in the access cycle
    always_ff @(posedge clk)
    begin
        if (access)
        begin
            prdata <= pwrite ? '0 : rd_data;
            mode_q <= wr_mode;
            count_q <= pwdata[APB_DATA_WIDTH-1:2];
        end
    end

    // Start is valid in the pready cycle
    assign cmd = '{start: start_q, mode: mode_q, count: count_q};

endmodule

// File: source/host_tester_route.sv
// Channel router: passthrough in normal mode, sink, source or loopback in test modes
// A start during a running test restarts it; a source count of 0 runs as 1
module host_tester_route
(
    input  logic                                  clk,
    input  logic                                  resetb,

    // Test command from the decoder
    input  host_tester_pkg::tester_cmd_t          cmd,

    // Channel toward the client
    output logic [host_tester_pkg::MSG_WIDTH-1:0] client_rx_data,
    output logic                                  client_rx_rdy,
    input  logic                                  client_rx_enable,

    // Channel from the client
    input  logic [host_tester_pkg::MSG_WIDTH-1:0] client_tx_data,
    output logic                                  client_tx_rdy,
    input  logic                                  client_tx_enable,

    // Host side of the rx channel
    input  logic [host_tester_pkg::MSG_WIDTH-1:0] host_rx_data,
    input  logic                                  host_rx_rdy,
    output logic                                  host_rx_enable,

    // Host side of the tx channel
    output logic [host_tester_pkg::MSG_WIDTH-1:0] host_tx_data,
    input  logic                                  host_tx_rdy,
    output logic                                  host_tx_enable,

    // Activity toward the recorder
    output host_tester_pkg::route_event_t         evt
);
    import host_tester_pkg::*;

    tester_mode_e           mode;
    logic [COUNT_WIDTH-1:0] load_count;
    logic [COUNT_WIDTH-1:0] src_count;
    logic [COUNT_WIDTH-1:0] sink_count;
    logic [COUNT_WIDTH-1:0] sink_total;
    logic                   src_last;
    logic                   test_done;

    // Zero count still sends one message
    assign load_count = (cmd.count == '0) ? COUNT_WIDTH'(1) : COUNT_WIDTH'(cmd.count);
    assign src_last = (src_count == COUNT_WIDTH'(1));
    // Accepted count including the message in flight
    assign sink_total = sink_count + COUNT_WIDTH'(1);

    // Data toward the client is a don't care outside normal mode
    assign client_rx_data = host_rx_data;

    always_comb
    begin
        // Client is cut off in every test mode
        client_rx_rdy = 1'b0;
        client_tx_rdy = 1'b0;
        host_rx_enable = client_rx_enable;
        host_tx_data = client_tx_data;
        host_tx_enable = client_tx_enable;
        test_done = 1'b0;

        case (mode)
            MODE_SINK:
            begin
                // Hold off host rx until the completion message could go out
                host_rx_enable = host_rx_rdy && host_tx_rdy;
                test_done = host_rx_enable && host_rx_data[0];
                host_tx_data = MSG_WIDTH'({sink_total, 1'b1});
                // Only the completion message
                host_tx_enable = test_done;
            end
            MODE_SOURCE:
            begin
                // Drain whatever the host sends
                host_rx_enable = host_rx_rdy;
                host_tx_data = MSG_WIDTH'({src_count, src_last});
                host_tx_enable = host_tx_rdy;
                test_done = host_tx_rdy && src_last;
            end
            MODE_LOOPBACK:
            begin
                // Accept only what can be echoed in the same cycle
                host_rx_enable = host_rx_rdy && host_tx_rdy;
                host_tx_data = host_rx_data;
                host_tx_enable = host_rx_enable;
                test_done = host_rx_enable && host_rx_data[0];
            end
            default:
            begin
                client_rx_rdy = host_rx_rdy;
                client_tx_rdy = host_tx_rdy;
            end
        endcase
    end

    // Mode register
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            mode <= MODE_NORMAL;
        end
        else if (cmd.start)
        begin
            mode <= cmd.mode;
        end
        else if (test_done)
        begin
            // Back to passthrough after the last message
            mode <= MODE_NORMAL;
        end
    end

    // Source down-counter and sink acceptance counter, set up by each start
    always_ff @(posedge clk)
    begin
        if (cmd.start)
        begin
            src_count <= load_count;
            sink_count <= '0;
        end
        else
        begin
            if ((mode == MODE_SOURCE) && host_tx_rdy)
            begin
                src_count <= src_count - COUNT_WIDTH'(1);
            end
            if ((mode == MODE_SINK) && host_rx_enable)
            begin
                sink_count <= sink_total;
            end
        end
    end

    // Source mode drains rx without counting it
    assign evt.mode = mode;
    assign evt.host_rx_fire = host_rx_rdy && host_rx_enable && (mode != MODE_SOURCE);
    assign evt.host_tx_fire = host_tx_rdy && host_tx_enable;
    assign evt.done = test_done;

endmodule

// File: source/host_tester_status.sv
// Test status recorder; a new test is seen as a change to a non-normal mode
// A restart in the same mode keeps adding to the running counts
module host_tester_status
(
    input  logic                            clk,
    input  logic                            resetb,

    // Activity from the router
    input  host_tester_pkg::route_event_t   evt,

    // Status block toward the decoder
    output host_tester_pkg::tester_status_t status
);
    import host_tester_pkg::*;

    tester_mode_e           mode_q;
    logic                   done_q;
    logic [COUNT_WIDTH-1:0] tx_count;
    logic [COUNT_WIDTH-1:0] rx_count;
    logic                   new_test;

    // First event cycle of a test mode
    assign new_test = (evt.mode != MODE_NORMAL) && (evt.mode != mode_q);

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            mode_q <= MODE_NORMAL;
            done_q <= 1'b0;
            tx_count <= '0;
            rx_count <= '0;
        end
        else
        begin
            mode_q <= evt.mode;
            if (new_test)
            begin
                // Restart the counts, keeping this cycle's transfers
                done_q <= evt.done;
                tx_count <= COUNT_WIDTH'(evt.host_tx_fire);
                rx_count <= COUNT_WIDTH'(evt.host_rx_fire);
            end
            else if (evt.mode != MODE_NORMAL)
            begin
                // Sticky until the next test
                done_q <= done_q || evt.done;
                tx_count <= tx_count + COUNT_WIDTH'(evt.host_tx_fire);
                rx_count <= rx_count + COUNT_WIDTH'(evt.host_rx_fire);
            end
        end
    end

    // Normal mode leaves the last totals in place
    assign status = '{
        mode:     mode_q,
        done:     done_q,
        tx_count: tx_count,
        rx_count: rx_count
    };

endmodule

// File: source/host_tester_top.sv
// Host tester node between a message driver and its client
// Reset leaves it in normal passthrough mode
module host_tester_top
(
    input  logic                                       clk,
    input  logic                                       resetb,

    // APB control port
    input  logic [host_tester_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic                                       psel,
    input  logic                                       penable,
    input  logic                                       pwrite,
    input  logic [host_tester_pkg::APB_DATA_WIDTH-1:0] pwdata,
    output logic [host_tester_pkg::APB_DATA_WIDTH-1:0] prdata,
    output logic                                       pready,
    output logic                                       pslverr,

    // Client side
    output logic [host_tester_pkg::MSG_WIDTH-1:0]      client_rx_data,
    output logic                                       client_rx_rdy,
    input  logic                                       client_rx_enable,
    input  logic [host_tester_pkg::MSG_WIDTH-1:0]      client_tx_data,
    output logic                                       client_tx_rdy,
    input  logic                                       client_tx_enable,

    // Host side
    input  logic [host_tester_pkg::MSG_WIDTH-1:0]      host_rx_data,
    input  logic                                       host_rx_rdy,
    output logic                                       host_rx_enable,
    output logic [host_tester_pkg::MSG_WIDTH-1:0]      host_tx_data,
    input  logic                                       host_tx_rdy,
    output logic                                       host_tx_enable
);
    import host_tester_pkg::*;

    tester_cmd_t    cmd;
    route_event_t   evt;
    tester_status_t status;

    // Register decode
    host_tester_csr host_tester_csr_i
    (
        .clk     (clk),
        .resetb  (resetb),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cmd     (cmd),
        .status  (status)
    );

    // Channel routing per mode
    host_tester_route host_tester_route_i
    (
        .clk              (clk),
        .resetb           (resetb),
        .cmd              (cmd),
        .client_rx_data   (client_rx_data),
        .client_rx_rdy    (client_rx_rdy),
        .client_rx_enable (client_rx_enable),
        .client_tx_data   (client_tx_data),
        .client_tx_rdy    (client_tx_rdy),
        .client_tx_enable (client_tx_enable),
        .host_rx_data     (host_rx_data),
        .host_rx_rdy      (host_rx_rdy),
        .host_rx_enable   (host_rx_enable),
        .host_tx_data     (host_tx_data),
        .host_tx_rdy      (host_tx_rdy),
        .host_tx_enable   (host_tx_enable),
        .evt              (evt)
    );

    // Per-test results
    host_tester_status host_tester_status_i
    (
        .clk    (clk),
        .resetb (resetb),
        .evt    (evt),
        .status (status)
    );

endmodule

// File: verification/host_tester_tb.sv
// Testbench for the host tester node; a channel model checks every cycle at the falling edge
// Stops at the first mismatch; all stimulus comes from a fixed-seed LFSR
module host_tester_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import host_tester_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT = 2000;

    logic                      clk = 1'b0;
    logic                      resetb;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_DATA_WIDTH-1:0] pwdata;
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
    logic [MSG_WIDTH-1:0]      client_rx_data;
    logic                      client_rx_rdy;
    logic                      client_rx_enable;
    logic [MSG_WIDTH-1:0]      client_tx_data;
    logic                      client_tx_rdy;
    logic                      client_tx_enable;
    logic [MSG_WIDTH-1:0]      host_rx_data;
    logic                      host_rx_rdy;
    logic                      host_rx_enable;
    logic [MSG_WIDTH-1:0]      host_tx_data;
    logic                      host_tx_rdy;
    logic                      host_tx_enable;

    // Model state: mode of the current cycle and of the next one
    tester_mode_e              cycle_mode;
    tester_mode_e              exp_mode;
    logic [COUNT_WIDTH-1:0]    src_left;
    logic [COUNT_WIDTH-1:0]    sink_seen;
    logic [31:0]               lfsr_state = 32'd67;

    host_tester_top host_tester_top_i (.*);

    always #4 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("FAIL at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("Error at %0d ns: %s", $time, what);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        assert (exp === act) else report_mismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic check_word(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else report_mismatch(name, exp, act);
    endtask

    // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic rand_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
        return b;
    endfunction

    function automatic logic [63:0] rand_word();
        logic [63:0] v;
        for (int i = 0; i < 64; i++)
            v[i] = rand_bit();
        return v;
    endfunction

    // Client outputs must stay low in every test mode
    assert property (@(posedge clk) disable iff (!resetb)
        (cycle_mode != MODE_NORMAL) |-> (!client_rx_rdy && !client_tx_rdy))
    else report_error("client ready flag raised during a test mode");

    // Loopback never takes a message it cannot echo
    assert property (@(posedge clk) disable iff (!resetb)
        (cycle_mode == MODE_LOOPBACK) |-> (host_tx_rdy || !host_rx_enable))
    else report_error("host_rx_enable high in loopback while host_tx_rdy low");

    // Exactly one wait state: pready only follows an access cycle
    assert property (@(posedge clk) disable iff (!resetb)
        pready |-> $past(psel && penable && !pready))
    else report_error("pready raised without a preceding APB access cycle");

    // Channel model, checked once per cycle where all inputs are settled
    always @(negedge clk)
    begin : channel_model
        logic exp_done;
        logic exp_rx_en;
        logic exp_tx_en;
        if (!resetb)
        begin
            cycle_mode = MODE_NORMAL;
            exp_mode = MODE_NORMAL;
        end
        else
        begin
            cycle_mode = exp_mode;
            exp_done = 1'b0;
            exp_rx_en = client_rx_enable;
            exp_tx_en = client_tx_enable;
            case (exp_mode)
                MODE_SINK:
                begin
                    exp_rx_en = host_rx_rdy && host_tx_rdy;
                    exp_done = exp_rx_en && host_rx_data[0];
                    exp_tx_en = exp_done;
                    // Completion carries the accepted count including the last one
                    if (exp_done)
                        check_word("host_tx_data",
                            64'({sink_seen + COUNT_WIDTH'(1), 1'b1}), host_tx_data);
                    if (exp_rx_en)
                        sink_seen = sink_seen + COUNT_WIDTH'(1);
                end
                MODE_SOURCE:
                begin
                    exp_rx_en = host_rx_rdy;
                    exp_tx_en = host_tx_rdy;
                    exp_done = host_tx_rdy && (src_left == COUNT_WIDTH'(1));
                    if (host_tx_rdy)
                    begin
                        check_word("host_tx_data",
                            64'({src_left, src_left == COUNT_WIDTH'(1)}), host_tx_data);
                        src_left = src_left - COUNT_WIDTH'(1);
                    end
                end
                MODE_LOOPBACK:
                begin
                    exp_rx_en = host_rx_rdy && host_tx_rdy;
                    exp_tx_en = exp_rx_en;
                    exp_done = exp_rx_en && host_rx_data[0];
                    if (exp_rx_en)
                        check_word("host_tx_data", host_rx_data, host_tx_data);
                end
                default:
                begin
                    // Plain passthrough
                    check_word("client_rx_data", host_rx_data, client_rx_data);
                    check_bit("client_rx_rdy", host_rx_rdy, client_rx_rdy);
                    check_bit("client_tx_rdy", host_tx_rdy, client_tx_rdy);
                    check_word("host_tx_data", client_tx_data, host_tx_data);
                end
            endcase
            check_bit("host_rx_enable", exp_rx_en, host_rx_enable);
            check_bit("host_tx_enable", exp_tx_en, host_tx_enable);
            if (exp_done)
            begin
                exp_mode = MODE_NORMAL;
            end
            // Start lands in the pready cycle of a REG_CTRL write with nonzero mode
            if (pready && psel && pwrite && (paddr == REG_CTRL) && (pwdata[1:0] != 2'b00))
            begin
                exp_mode = tester_mode_e'(pwdata[1:0]);
                src_left = (pwdata[31:2] == '0) ? COUNT_WIDTH'(1) : COUNT_WIDTH'(pwdata[31:2]);
                sink_seen = '0;
            end
        end
    end

    // Single APB transfer, returns on the edge that ends the pready cycle
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= write;
        paddr <= addr;
        pwdata <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        while (!pready)
        begin
            if (waited >= WAIT_LIMIT)
                report_error("timeout waiting for pready");
            else
            begin
                @(posedge clk);
                waited++;
            end
        end
        rdata = prdata;
        err = pslverr;
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused_rd;
        apb_transfer(1'b1, addr, data, unused_rd, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb_transfer(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic read_expect(input string name, input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        logic        err;
        apb_read(addr, rd, err);
        check_bit({"pslverr on read of ", name}, 1'b0, err);
        check_word({"prdata of ", name}, 64'(exp), 64'(rd));
    endtask

    task automatic start_test(input tester_mode_e mode, input logic [29:0] count);
        logic err;
        apb_write(REG_CTRL, {count, mode}, err);
        check_bit("pslverr on REG_CTRL write", 1'b0, err);
    endtask

    // Channels quiet, host always ready to take tx
    task automatic idle_channels();
        host_rx_rdy <= 1'b0;
        host_tx_rdy <= 1'b1;
        client_rx_enable <= 1'b0;
        client_tx_enable <= 1'b0;
    endtask

    task automatic run_random(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            host_rx_data <= rand_word();
            host_rx_rdy <= rand_bit();
            host_tx_rdy <= rand_bit();
            client_tx_data <= rand_word();
            client_rx_enable <= rand_bit();
            client_tx_enable <= rand_bit();
        end
        idle_channels();
    endtask

    // Host sends n messages, bit 0 set only on the last, under random tx back-pressure
    task automatic send_host(input int n);
        int          sent;
        int          waited;
        logic [63:0] msg;
        sent = 0;
        waited = 0;
        msg = rand_word();
        msg[0] = (n == 1);
        host_rx_data <= msg;
        host_rx_rdy <= 1'b1;
        while (sent < n)
        begin
            @(posedge clk);
            host_tx_rdy <= rand_bit();
            if (host_rx_rdy && host_rx_enable)
            begin
                sent++;
                waited = 0;
                msg = rand_word();
                msg[0] = (sent == n - 1);
                host_rx_data <= msg;
            end
            else if (waited >= WAIT_LIMIT)
                report_error("timeout waiting for the node to accept a host message");
            else
                waited++;
        end
        idle_channels();
    endtask

    // Random host traffic until the model says the next cycle is normal
    task automatic wait_normal();
        int waited;
        waited = 0;
        while (exp_mode != MODE_NORMAL)
        begin
            if (waited >= WAIT_LIMIT)
                report_error("timeout waiting for the return to normal mode");
            else
            begin
                @(posedge clk);
                host_rx_data <= rand_word();
                host_rx_rdy <= rand_bit();
                host_tx_rdy <= rand_bit();
                waited++;
            end
        end
        idle_channels();
    endtask

    // Done set, mode normal, and the totals of the last test
    task automatic check_results(input int exp_tx, input int exp_rx);
        read_expect("REG_STATUS", REG_STATUS, 32'h4);
        read_expect("REG_TX_COUNT", REG_TX_COUNT, 32'(exp_tx));
        read_expect("REG_RX_COUNT", REG_RX_COUNT, 32'(exp_rx));
    endtask

    initial
    begin
        logic [31:0] rd;
        logic        err;
        resetb = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        client_rx_enable = 1'b0;
        client_tx_data = '0;
        client_tx_enable = 1'b0;
        host_rx_data = '0;
        host_rx_rdy = 1'b0;
        host_tx_rdy = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetb <= 1'b1;

        // Reset state and passthrough
        @(posedge clk);
        check_bit("pready", 1'b0, pready);
        read_expect("REG_STATUS", REG_STATUS, 32'h0);
        run_random(200);

        // Source burst of 7 under back-pressure
        start_test(MODE_SOURCE, 30'd7);
        wait_normal();
        check_results(7, 0);

        // Loopback of 9 messages
        start_test(MODE_LOOPBACK, 30'd0);
        send_host(9);
        wait_normal();
        check_results(9, 9);

        // Sink of 6 messages, one completion message back
        start_test(MODE_SINK, 30'd0);
        send_host(6);
        wait_normal();
        check_results(1, 6);

        // APB error responses
        apb_read(8'h10, rd, err);
        check_bit("pslverr on unmapped read", 1'b1, err);
        apb_write(REG_STATUS, 32'h1, err);
        check_bit("pslverr on REG_STATUS write", 1'b1, err);
        apb_read(REG_CTRL, rd, err);
        check_bit("pslverr on REG_CTRL read", 1'b1, err);

        // Mode 0 write is ignored, passthrough keeps running
        apb_write(REG_CTRL, {30'd5, MODE_NORMAL}, err);
        check_bit("pslverr on REG_CTRL write", 1'b0, err);
        run_random(40);
        read_expect("REG_STATUS", REG_STATUS, 32'h4);

        // Stalled source test shows its running mode
        host_tx_rdy <= 1'b0;
        start_test(MODE_SOURCE, 30'd3);
        read_expect("REG_STATUS", REG_STATUS, {30'd0, MODE_SOURCE});
        wait_normal();
        check_results(3, 0);

        repeat (4) @(posedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: host_tester.f
source/host_tester_pkg.sv
source/host_tester_csr.sv
source/host_tester_route.sv
source/host_tester_status.sv
source/host_tester_top.sv
verification/host_tester_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= host_tester_tb
FILELIST  ?= host_tester.f
BUILD_DIR ?= obj_dir
PASS_MSG  := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator, run it and check for the pass message"
	@echo "  clean  remove the Verilator build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
